/* all.f */
+incdir+.
rv_isa_pkg.sv
ex_pkg.sv
ex_alu.sv
ex_multiplier.sv
ex_divider.sv
ex_unit.sv
tb_ex_unit.sv

/* ex_alu.sv */
// RV64I single-cycle ALU, purely combinational
// shift amounts come from the low bits of op2, lui_auipc takes imm[19:0] in op2
// multiply and divide codes give zero here
`timescale 1ns/1ns
`include "ex_macros.svh"

module ex_alu (
    input  rv_isa_pkg::ex_op_e   op_i,
    input  logic [`EX_XLEN-1:0]  op1_i,
    input  logic [`EX_XLEN-1:0]  op2_i,
    input  logic [`EX_XLEN-1:0]  pc_i,
    output logic [`EX_XLEN-1:0]  rd_data_o
);

    localparam int XLEN = `EX_XLEN;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [5:0]      shamt;
    logic [4:0]      shamt_w;
    logic [XLEN-1:0] sra_res;
    logic [31:0]     sllw_lo;
    logic [31:0]     srlw_lo;
    logic [31:0]     sraw_lo;
    logic [XLEN-1:0] upper_imm;

    assign sum  = op1_i + op2_i;
    assign diff = op1_i + (~op2_i + 1'b1);

    // signs differ: op1 negative wins, else look at the difference
    assign lt_signed = (op1_i[XLEN-1] & ~op2_i[XLEN-1]) |
                       (~(op1_i[XLEN-1] ^ op2_i[XLEN-1]) & diff[XLEN-1]);
    assign lt_unsigned = op1_i < op2_i;

    assign shamt   = op2_i[5:0];
    assign shamt_w = op2_i[4:0];

    // arithmetic shift as logical shift plus sign fill
    assign sra_res = ({XLEN{op1_i[XLEN-1]}} << (7'd64 - {1'b0, shamt})) |
                     (op1_i >> shamt);

    assign sllw_lo = op1_i[31:0] << shamt_w;
    assign srlw_lo = op1_i[31:0] >> shamt_w;
    assign sraw_lo = ({32{op1_i[31]}} << (6'd32 - {1'b0, shamt_w})) |
                     (op1_i[31:0] >> shamt_w);

    assign upper_imm = {{(XLEN-32){op2_i[19]}}, op2_i[19:0], 12'd0};

    always_comb begin
        case (op_i)
            rv_isa_pkg::OP_ADD:       rd_data_o = sum;
            rv_isa_pkg::OP_SUB:       rd_data_o = diff;
            rv_isa_pkg::OP_SLL:       rd_data_o = op1_i << shamt;
            rv_isa_pkg::OP_SLT:       rd_data_o = {{(XLEN-1){1'b0}}, lt_signed};
            rv_isa_pkg::OP_SLTU:      rd_data_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            rv_isa_pkg::OP_XOR:       rd_data_o = op1_i ^ op2_i;
            rv_isa_pkg::OP_SRL:       rd_data_o = op1_i >> shamt;
            rv_isa_pkg::OP_SRA:       rd_data_o = sra_res;
            rv_isa_pkg::OP_OR:        rd_data_o = op1_i | op2_i;
            rv_isa_pkg::OP_AND:       rd_data_o = op1_i & op2_i;
            rv_isa_pkg::OP_ADDW:      rd_data_o = rv_isa_pkg::sext_w(sum[31:0]);
            rv_isa_pkg::OP_SUBW:      rd_data_o = rv_isa_pkg::sext_w(diff[31:0]);
            rv_isa_pkg::OP_SLLW:      rd_data_o = rv_isa_pkg::sext_w(sllw_lo);
            rv_isa_pkg::OP_SRLW:      rd_data_o = rv_isa_pkg::sext_w(srlw_lo);
            rv_isa_pkg::OP_SRAW:      rd_data_o = rv_isa_pkg::sext_w(sraw_lo);
            rv_isa_pkg::OP_LUI_AUIPC: rd_data_o = op1_i + upper_imm;
            // return address for jal and jalr
            rv_isa_pkg::OP_LINK:      rd_data_o = pc_i + 64'd4;
            default:                  rd_data_o = '0;
        endcase
    end

endmodule

/* ex_divider.sv */
// iterative restoring divider, one quotient bit per cycle
// done_o comes 65 cycles after start_i, or 1 cycle for divide by zero and overflow
// start_i must not be raised again before done_o
`timescale 1ns/1ns
`include "ex_macros.svh"

module ex_divider (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  rv_isa_pkg::ex_op_e  op_i,
    input  logic [`EX_XLEN-1:0] dividend_i,
    input  logic [`EX_XLEN-1:0] divisor_i,
    output logic [`EX_XLEN-1:0] result_o,
    output logic                done_o
);

    localparam int XLEN = `EX_XLEN;

    logic            is_w;
    logic            is_signed;
    logic            want_rem;
    logic [XLEN-1:0] a_ext;
    logic [XLEN-1:0] b_ext;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic [XLEN-1:0] min_neg;
    logic            div_zero;
    logic            overflow;
    logic [XLEN-1:0] early_res;
    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   trial;
    logic [XLEN-1:0] rem_next;
    logic [XLEN-1:0] quot_next;
    logic [XLEN-1:0] quot_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] final_res;

    logic            run_q;
    logic            done_q;
    logic [5:0]      cnt_q;
    logic [XLEN-1:0] quot_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dvsr_q;
    logic            neg_quot_q;
    logic            neg_rem_q;
    logic            want_rem_q;
    logic            is_w_q;
    logic [XLEN-1:0] result_q;

    assign is_w = op_i inside {rv_isa_pkg::OP_DIVW, rv_isa_pkg::OP_DIVUW,
                               rv_isa_pkg::OP_REMW, rv_isa_pkg::OP_REMUW};
    assign is_signed = op_i inside {rv_isa_pkg::OP_DIV, rv_isa_pkg::OP_REM,
                                    rv_isa_pkg::OP_DIVW, rv_isa_pkg::OP_REMW};
    assign want_rem = op_i inside {rv_isa_pkg::OP_REM, rv_isa_pkg::OP_REMU,
                                   rv_isa_pkg::OP_REMW, rv_isa_pkg::OP_REMUW};

    // narrow W operands, then a[63] is the true sign in every form
    assign a_ext = !is_w     ? dividend_i :
                   is_signed ? rv_isa_pkg::sext_w(dividend_i[31:0]) :
                               {{(XLEN-32){1'b0}}, dividend_i[31:0]};
    assign b_ext = !is_w     ? divisor_i :
                   is_signed ? rv_isa_pkg::sext_w(divisor_i[31:0]) :
                               {{(XLEN-32){1'b0}}, divisor_i[31:0]};

    assign abs_a = (is_signed && a_ext[XLEN-1]) ? -a_ext : a_ext;
    assign abs_b = (is_signed && b_ext[XLEN-1]) ? -b_ext : b_ext;

    assign min_neg  = is_w ? {{(XLEN-31){1'b1}}, 31'd0} : {1'b1, {(XLEN-1){1'b0}}};
    assign div_zero = (b_ext == '0);
    assign overflow = is_signed && (a_ext == min_neg) && (&b_ext);

    // spec answers for the two early cases
    assign early_res = div_zero ? (want_rem ? a_ext : '1) : (want_rem ? '0 : a_ext);

    assign rem_shift = {rem_q, quot_q[XLEN-1]};
    assign trial     = rem_shift - {1'b0, dvsr_q};
    assign rem_next  = trial[XLEN] ? rem_shift[XLEN-1:0] : trial[XLEN-1:0];
    assign quot_next = {quot_q[XLEN-2:0], ~trial[XLEN]};

    assign quot_fix  = neg_quot_q ? -quot_next : quot_next;
    assign rem_fix   = neg_rem_q ? -rem_next : rem_next;
    assign final_res = want_rem_q ? rem_fix : quot_fix;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                cnt_q <= '0;
                if (div_zero || overflow) begin
                    done_q <= 1'b1;
                end else begin
                    run_q <= 1'b1;
                end
            end else if (run_q) begin
                cnt_q <= cnt_q + 6'd1;
                if (cnt_q == 6'd63) begin
                    run_q  <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quot_q     <= abs_a;
            rem_q      <= '0;
            dvsr_q     <= abs_b;
            neg_quot_q <= is_signed && (a_ext[XLEN-1] ^ b_ext[XLEN-1]);
            neg_rem_q  <= is_signed && a_ext[XLEN-1];
            want_rem_q <= want_rem;
            is_w_q     <= is_w;
            result_q   <= is_w ? rv_isa_pkg::sext_w(early_res[31:0]) : early_res;
        end else if (run_q) begin
            quot_q <= quot_next;
            rem_q  <= rem_next;
            if (cnt_q == 6'd63) begin
                result_q <= is_w_q ? rv_isa_pkg::sext_w(final_res[31:0]) : final_res;
            end
        end
    end

    assign result_o = result_q;
    assign done_o   = done_q;

endmodule

/* ex_macros.svh */
// widths and latencies shared by the execute stage and its testbench
// EX_MUL_LAT must be 3 or more (extend, product, select)
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// operand and result width
`define EX_XLEN 64

// register index width
`define EX_REG_ADDR_W 5

// multiplier pipeline depth, start to done
`define EX_MUL_LAT 3

`endif

/* ex_multiplier.sv */
// pipelined 64x64 multiplier, done_o follows start_i by EX_MUL_LAT cycles
// accepts a new start every cycle, product_o is valid with done_o only
`timescale 1ns/1ns
`include "ex_macros.svh"

module ex_multiplier (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  rv_isa_pkg::ex_op_e  op_i,
    input  logic [`EX_XLEN-1:0] op1_i,
    input  logic [`EX_XLEN-1:0] op2_i,
    output logic [`EX_XLEN-1:0] product_o,
    output logic                done_o
);

    localparam int XLEN = `EX_XLEN;
    localparam int LAT  = `EX_MUL_LAT;

    logic                     op1_signed;
    logic                     op2_signed;
    logic [LAT-1:0]           vld_q;
    rv_isa_pkg::ex_op_e       op_q [LAT-1];
    logic signed [XLEN:0]     a_q;
    logic signed [XLEN:0]     b_q;
    logic signed [2*XLEN+1:0] prod_q [LAT-2];
    logic [XLEN-1:0]          product_q;

    // mulhu is fully unsigned, mulhsu only on op2
    assign op1_signed = (op_i != rv_isa_pkg::OP_MULHU);
    assign op2_signed = (op_i != rv_isa_pkg::OP_MULHU) && (op_i != rv_isa_pkg::OP_MULHSU);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LAT-2:0], start_i};
        end
    end

    always_ff @(posedge clk) begin
        a_q       <= {op1_signed & op1_i[XLEN-1], op1_i};
        b_q       <= {op2_signed & op2_i[XLEN-1], op2_i};
        op_q[0]   <= op_i;
        prod_q[0] <= a_q * b_q;
        for (int i = 1; i < LAT - 1; i++) begin
            op_q[i] <= op_q[i-1];
        end
        for (int i = 1; i < LAT - 2; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
        // last stage picks the half
        case (op_q[LAT-2])
            rv_isa_pkg::OP_MUL:  product_q <= prod_q[LAT-3][XLEN-1:0];
            rv_isa_pkg::OP_MULW: product_q <= rv_isa_pkg::sext_w(prod_q[LAT-3][31:0]);
            default:             product_q <= prod_q[LAT-3][2*XLEN-1:XLEN];
        endcase
    end

    assign product_o = product_q;
    assign done_o    = vld_q[LAT-1];

endmodule

/* ex_pkg.sv */
// structs that carry an instruction into and a result out of execute
// operands arrive already selected by decode
`include "ex_macros.svh"

package ex_pkg;

    typedef struct packed {
        rv_isa_pkg::ex_op_e          op;
        logic [`EX_XLEN-1:0]         op1;
        logic [`EX_XLEN-1:0]         op2;
        logic [`EX_XLEN-1:0]         pc;
        logic [`EX_REG_ADDR_W-1:0]   rd_addr;
        logic                        rd_en;
    } ex_issue_t;

    // write-back record, pc kept for the retire side
    typedef struct packed {
        logic [`EX_XLEN-1:0]         pc;
        logic [`EX_REG_ADDR_W-1:0]   rd_addr;
        logic                        rd_en;
        logic [`EX_XLEN-1:0]         rd_data;
    } ex_result_t;

endpackage

/* ex_unit.sv */
// RV64IM execute stage, holds one instruction at a time
// ALU result 1 cycle after accept, multiply EX_MUL_LAT+1, divide up to 66
// issue_ready_o depends combinationally on result_ready_i
`timescale 1ns/1ns
`include "ex_macros.svh"

module ex_unit (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               issue_valid_i,
    input  ex_pkg::ex_issue_t  issue_i,
    output logic               issue_ready_o,
    output logic               result_valid_o,
    output ex_pkg::ex_result_t result_o,
    input  logic               result_ready_i,
    output logic               busy_o
);

    logic                      accept;
    rv_isa_pkg::ex_class_e     cls;
    logic [`EX_XLEN-1:0]       alu_data;
    logic                      mul_start;
    logic                      mul_done;
    logic [`EX_XLEN-1:0]       mul_data;
    logic                      div_start;
    logic                      div_done;
    logic [`EX_XLEN-1:0]       div_data;
    logic                      inflight_q;
    logic                      res_valid_q;
    ex_pkg::ex_result_t        result_q;

    assign cls           = rv_isa_pkg::op_class(issue_i.op);
    assign issue_ready_o = !inflight_q && (!res_valid_q || result_ready_i);
    assign accept        = issue_valid_i && issue_ready_o;
    assign mul_start     = accept && (cls == rv_isa_pkg::CLASS_MUL);
    assign div_start     = accept && (cls == rv_isa_pkg::CLASS_DIV);

    ex_alu u_alu (
        .op_i      (issue_i.op),
        .op1_i     (issue_i.op1),
        .op2_i     (issue_i.op2),
        .pc_i      (issue_i.pc),
        .rd_data_o (alu_data)
    );

    ex_multiplier u_mul (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (mul_start),
        .op_i      (issue_i.op),
        .op1_i     (issue_i.op1),
        .op2_i     (issue_i.op2),
        .product_o (mul_data),
        .done_o    (mul_done)
    );

    ex_divider u_div (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .op_i       (issue_i.op),
        .dividend_i (issue_i.op1),
        .divisor_i  (issue_i.op2),
        .result_o   (div_data),
        .done_o     (div_done)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inflight_q  <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            if (res_valid_q && result_ready_i) begin
                res_valid_q <= 1'b0;
            end
            if (accept) begin
                if (cls == rv_isa_pkg::CLASS_ALU) begin
                    res_valid_q <= 1'b1;
                end else begin
                    inflight_q <= 1'b1;
                end
            end
            // engine finished, result register is empty at this point
            if (mul_done || div_done) begin
                inflight_q  <= 1'b0;
                res_valid_q <= 1'b1;
            end
        end
    end

    // metadata goes straight into the result register, data follows on done
    always_ff @(posedge clk) begin
        if (accept) begin
            result_q.pc      <= issue_i.pc;
            result_q.rd_addr <= issue_i.rd_addr;
            result_q.rd_en   <= issue_i.rd_en;
            if (cls == rv_isa_pkg::CLASS_ALU) begin
                result_q.rd_data <= alu_data;
            end
        end else if (mul_done) begin
            result_q.rd_data <= mul_data;
        end else if (div_done) begin
            result_q.rd_data <= div_data;
        end
    end

    assign result_valid_o = res_valid_q;
    assign result_o       = result_q;
    assign busy_o         = inflight_q;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_ex_unit -o sim_ex_unit &&
./obj_dir/sim_ex_unit ||
{ echo "simulation run failed"; exit 1; }

/* rv_isa_pkg.sv */
// execute operation codes and their grouping into engine classes
// immediate and register forms share one code, decode picks op2
`include "ex_macros.svh"

package rv_isa_pkg;

    typedef enum logic [5:0] {
        OP_ADD       = 6'h00,
        OP_SUB       = 6'h01,
        OP_SLL       = 6'h02,
        OP_SLT       = 6'h03,
        OP_SLTU      = 6'h04,
        OP_XOR       = 6'h05,
        OP_SRL       = 6'h06,
        OP_SRA       = 6'h07,
        OP_OR        = 6'h08,
        OP_AND       = 6'h09,
        OP_ADDW      = 6'h0a,
        OP_SUBW      = 6'h0b,
        OP_SLLW      = 6'h0c,
        OP_SRLW      = 6'h0d,
        OP_SRAW      = 6'h0e,
        OP_LUI_AUIPC = 6'h0f,
        OP_LINK      = 6'h10,
        OP_MUL       = 6'h20,
        OP_MULH      = 6'h21,
        OP_MULHSU    = 6'h22,
        OP_MULHU     = 6'h23,
        OP_MULW      = 6'h24,
        OP_DIV       = 6'h30,
        OP_DIVU      = 6'h31,
        OP_REM       = 6'h32,
        OP_REMU      = 6'h33,
        OP_DIVW      = 6'h34,
        OP_DIVUW     = 6'h35,
        OP_REMW      = 6'h36,
        OP_REMUW     = 6'h37
    } ex_op_e;

    typedef enum logic [1:0] {
        CLASS_ALU = 2'd0,
        CLASS_MUL = 2'd1,
        CLASS_DIV = 2'd2
    } ex_class_e;

    function automatic ex_class_e op_class(input ex_op_e op);
        ex_class_e cls;
        case (op)
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW: cls = CLASS_MUL;
            OP_DIV, OP_DIVU, OP_REM, OP_REMU,
            OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW:          cls = CLASS_DIV;
            default:                                       cls = CLASS_ALU;
        endcase
        return cls;
    endfunction

    // W results are sign-extended from bit 31
    function automatic logic [`EX_XLEN-1:0] sext_w(input logic [31:0] v);
        return {{(`EX_XLEN-32){v[31]}}, v};
    endfunction

endpackage

/* tb_ex_unit.sv */
// directed testbench for the execute stage, expected values from a behavioral model
// stops at the first mismatch or timeout, every wait is bounded
`timescale 1ns/1ns
`include "ex_macros.svh"

module tb_ex_unit;

    localparam int XLEN        = `EX_XLEN;
    localparam int WAIT_MAX    = 100;
    localparam int NUM_CORNERS = 10;
    localparam logic [XLEN-1:0] CORNERS [NUM_CORNERS] = '{
        64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_001f,
        64'h0000_0000_0000_0020, 64'h0000_0000_0000_003f, 64'h7fff_ffff_ffff_ffff,
        64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_8000_0000,
        64'h0000_0000_7fff_ffff
    };

    logic               clk;
    logic               rst_n_i;
    logic               issue_valid_i;
    ex_pkg::ex_issue_t  issue_i;
    logic               issue_ready_o;
    logic               result_valid_o;
    ex_pkg::ex_result_t result_o;
    logic               result_ready_i;
    logic               busy_o;

    ex_unit u_ex_unit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .issue_ready_o  (issue_ready_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_ready_i (result_ready_i),
        .busy_o         (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_eq(input string name, input logic [XLEN-1:0] exp_v,
                            input logic [XLEN-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("[ERROR] time %0t: %s expected 0x%h, actual 0x%h",
                     $time, name, exp_v, act_v);
            stop_run();
        end
    endtask

    function automatic logic [XLEN-1:0] sign_extend_word(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // RV64IM write-back value, straight from the ISA rules
    function automatic logic [XLEN-1:0] model_rd(input ex_pkg::ex_issue_t ins);
        logic [63:0]        a;
        logic [63:0]        b;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [31:0]        aw;
        logic [31:0]        bw;
        logic signed [31:0] saw;
        logic signed [31:0] sbw;
        logic [31:0]        rw;
        logic [127:0]       xa;
        logic [127:0]       xb;
        logic [127:0]       full;
        logic               rem_form;
        logic [63:0]        r;
        a        = ins.op1;
        b        = ins.op2;
        sa       = a;
        sb       = b;
        aw       = a[31:0];
        bw       = b[31:0];
        saw      = aw;
        sbw      = bw;
        rw       = '0;
        rem_form = (ins.op == rv_isa_pkg::OP_REM) || (ins.op == rv_isa_pkg::OP_REMW);
        // mulhu is unsigned on both sides, mulhsu only on op2
        xa   = {{64{a[63] && (ins.op != rv_isa_pkg::OP_MULHU)}}, a};
        xb   = {{64{b[63] && (ins.op != rv_isa_pkg::OP_MULHU)
                         && (ins.op != rv_isa_pkg::OP_MULHSU)}}, b};
        full = xa * xb;
        case (ins.op)
            rv_isa_pkg::OP_ADD:       r = a + b;
            rv_isa_pkg::OP_SUB:       r = a - b;
            rv_isa_pkg::OP_SLL:       r = a << b[5:0];
            rv_isa_pkg::OP_SLT:       r = {63'd0, sa < sb};
            rv_isa_pkg::OP_SLTU:      r = {63'd0, a < b};
            rv_isa_pkg::OP_XOR:       r = a ^ b;
            rv_isa_pkg::OP_SRL:       r = a >> b[5:0];
            rv_isa_pkg::OP_SRA:       r = sa >>> b[5:0];
            rv_isa_pkg::OP_OR:        r = a | b;
            rv_isa_pkg::OP_AND:       r = a & b;
            rv_isa_pkg::OP_ADDW:      r = sign_extend_word(aw + bw);
            rv_isa_pkg::OP_SUBW:      r = sign_extend_word(aw - bw);
            rv_isa_pkg::OP_SLLW:      r = sign_extend_word(aw << b[4:0]);
            rv_isa_pkg::OP_SRLW:      r = sign_extend_word(aw >> b[4:0]);
            rv_isa_pkg::OP_SRAW:      r = sign_extend_word(saw >>> b[4:0]);
            rv_isa_pkg::OP_LUI_AUIPC: r = a + sign_extend_word({b[19:0], 12'd0});
            rv_isa_pkg::OP_LINK:      r = ins.pc + 64'd4;
            rv_isa_pkg::OP_MUL:       r = full[63:0];
            rv_isa_pkg::OP_MULW:      r = sign_extend_word(full[31:0]);
            rv_isa_pkg::OP_MULH, rv_isa_pkg::OP_MULHSU, rv_isa_pkg::OP_MULHU: begin
                r = full[127:64];
            end
            rv_isa_pkg::OP_DIV, rv_isa_pkg::OP_REM: begin
                if (b == '0) begin
                    r = rem_form ? a : '1;
                end else if ((a == {1'b1, 63'd0}) && (&b)) begin
                    r = rem_form ? '0 : a;
                end else if (rem_form) begin
                    r = sa % sb;
                end else begin
                    r = sa / sb;
                end
            end
            rv_isa_pkg::OP_DIVU:      r = (b == '0) ? '1 : a / b;
            rv_isa_pkg::OP_REMU:      r = (b == '0) ? a : a % b;
            rv_isa_pkg::OP_DIVW, rv_isa_pkg::OP_REMW: begin
                if (bw == '0) begin
                    rw = rem_form ? aw : '1;
                end else if ((aw == 32'h8000_0000) && (&bw)) begin
                    rw = rem_form ? '0 : aw;
                end else if (rem_form) begin
                    rw = saw % sbw;
                end else begin
                    rw = saw / sbw;
                end
                r = sign_extend_word(rw);
            end
            rv_isa_pkg::OP_DIVUW:     r = sign_extend_word((bw == '0) ? '1 : aw / bw);
            rv_isa_pkg::OP_REMUW:     r = sign_extend_word((bw == '0) ? aw : aw % bw);
            default:                  r = '0;
        endcase
        return r;
    endfunction

    // cycles from the accepting edge until result_valid_o is seen
    function automatic int expected_latency(input ex_pkg::ex_issue_t ins);
        logic sgn;
        logic zero;
        logic ovf;
        int   lat;
        sgn  = (ins.op == rv_isa_pkg::OP_DIV) || (ins.op == rv_isa_pkg::OP_REM) ||
               (ins.op == rv_isa_pkg::OP_DIVW) || (ins.op == rv_isa_pkg::OP_REMW);
        zero = 1'b0;
        ovf  = 1'b0;
        lat  = 1;
        case (ins.op)
            rv_isa_pkg::OP_MUL, rv_isa_pkg::OP_MULH, rv_isa_pkg::OP_MULHSU,
            rv_isa_pkg::OP_MULHU, rv_isa_pkg::OP_MULW: begin
                lat = `EX_MUL_LAT + 1;
            end
            rv_isa_pkg::OP_DIV, rv_isa_pkg::OP_DIVU, rv_isa_pkg::OP_REM,
            rv_isa_pkg::OP_REMU: begin
                zero = (ins.op2 == '0);
                ovf  = sgn && (ins.op1 == {1'b1, 63'd0}) && (&ins.op2);
                lat  = (zero || ovf) ? 2 : 66;
            end
            rv_isa_pkg::OP_DIVW, rv_isa_pkg::OP_DIVUW, rv_isa_pkg::OP_REMW,
            rv_isa_pkg::OP_REMUW: begin
                zero = (ins.op2[31:0] == '0);
                ovf  = sgn && (ins.op1[31:0] == 32'h8000_0000) && (&ins.op2[31:0]);
                lat  = (zero || ovf) ? 2 : 66;
            end
            default: lat = 1;
        endcase
        return lat;
    endfunction

    function automatic ex_pkg::ex_issue_t make_instr(input rv_isa_pkg::ex_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        ex_pkg::ex_issue_t ins;
        ins.op      = op;
        ins.op1     = a;
        ins.op2     = b;
        ins.pc      = rand64() & ~64'h3;
        ins.rd_addr = 5'($urandom);
        ins.rd_en   = 1'($urandom);
        return ins;
    endfunction

    function automatic ex_pkg::ex_result_t expected_result(input ex_pkg::ex_issue_t ins);
        ex_pkg::ex_result_t res;
        res.pc      = ins.pc;
        res.rd_addr = ins.rd_addr;
        res.rd_en   = ins.rd_en;
        res.rd_data = model_rd(ins);
        return res;
    endfunction

    task automatic compare_result(input ex_pkg::ex_result_t exp_r,
                                  input ex_pkg::ex_result_t got_r);
        check_eq("result_o.rd_data", exp_r.rd_data, got_r.rd_data);
        check_eq("result_o.pc", exp_r.pc, got_r.pc);
        check_eq("result_o.rd_addr", exp_r.rd_addr, got_r.rd_addr);
        check_eq("result_o.rd_en", exp_r.rd_en, got_r.rd_en);
    endtask

    // returns right after the accepting edge
    task automatic send_instr(input ex_pkg::ex_issue_t ins);
        int n;
        @(posedge clk);
        issue_valid_i <= 1'b1;
        issue_i       <= ins;
        n = 0;
        @(negedge clk);
        while (!issue_ready_o) begin
            n++;
            if (n > WAIT_MAX) begin
                $display("timeout: instruction was never accepted");
                stop_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        issue_valid_i <= 1'b0;
    endtask

    task automatic run_op(input ex_pkg::ex_issue_t ins);
        int n;
        int lat;
        lat = expected_latency(ins);
        send_instr(ins);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                $display("timeout: no result for op 0x%h", ins.op);
                stop_run();
            end
            if (!result_valid_o) begin
                check_eq("busy_o", lat > 1, busy_o);
                check_eq("issue_ready_o", 1'b0, issue_ready_o);
            end
        end while (!result_valid_o);
        check_eq("latency", lat, n);
        check_eq("busy_o", 1'b0, busy_o);
        compare_result(expected_result(ins), result_o);
    endtask

    task automatic sweep(input rv_isa_pkg::ex_op_e first, input rv_isa_pkg::ex_op_e last,
                         input int n_rand);
        rv_isa_pkg::ex_op_e op;
        for (int k = int'(first); k <= int'(last); k++) begin
            op = rv_isa_pkg::ex_op_e'(6'(k));
            for (int i = 0; i < NUM_CORNERS; i++) begin
                for (int j = 0; j < NUM_CORNERS; j++) begin
                    run_op(make_instr(op, CORNERS[i], CORNERS[j]));
                end
            end
            // narrow divisors now and then so quotients are not always 0 or 1
            repeat (n_rand) begin
                run_op(make_instr(op, rand64(), rand64() >> ($urandom % 64)));
            end
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_eq("result_valid_o", 1'b0, result_valid_o);
        check_eq("busy_o", 1'b0, busy_o);
        check_eq("issue_ready_o", 1'b1, issue_ready_o);
    endtask

    task automatic alu_ops();
        sweep(rv_isa_pkg::OP_ADD, rv_isa_pkg::OP_LINK, 20);
    endtask

    task automatic multiply_ops();
        sweep(rv_isa_pkg::OP_MUL, rv_isa_pkg::OP_MULW, 30);
        run_op(make_instr(rv_isa_pkg::OP_MULH, 64'hffff_ffff_ffff_fffe, 64'h7fff_ffff_ffff_ffff));
        run_op(make_instr(rv_isa_pkg::OP_MULHSU, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff));
        run_op(make_instr(rv_isa_pkg::OP_MULW, 64'h0000_0000_7fff_ffff, 64'h0000_0000_0000_0003));
    endtask

    task automatic divide_ops();
        sweep(rv_isa_pkg::OP_DIV, rv_isa_pkg::OP_REMUW, 20);
        // W forms ignore the upper operand bits
        run_op(make_instr(rv_isa_pkg::OP_DIVW, 64'h1234_5678_8000_0000, 64'hdead_beef_ffff_ffff));
        run_op(make_instr(rv_isa_pkg::OP_REMW, 64'h1234_5678_8000_0000, 64'hdead_beef_ffff_ffff));
        run_op(make_instr(rv_isa_pkg::OP_DIVUW, 64'h0bad_0000_8765_4321, 64'hffff_ffff_0000_0000));
        run_op(make_instr(rv_isa_pkg::OP_REMUW, 64'h0bad_0000_8765_4321, 64'hffff_ffff_0000_0000));
        run_op(make_instr(rv_isa_pkg::OP_REM, 64'hffff_ffff_ffff_fff9, 64'h0000_0000_0000_0002));
    endtask

    // holds each result for a few cycles before taking it, in issue order
    task automatic collect_results(input ex_pkg::ex_result_t exp_q [$]);
        ex_pkg::ex_result_t held;
        int                 n;
        int                 hold;
        while (exp_q.size() > 0) begin
            n = 0;
            @(negedge clk);
            while (!result_valid_o) begin
                n++;
                if (n > WAIT_MAX) begin
                    $display("timeout: result missing in the mixed sequence");
                    stop_run();
                end
                @(negedge clk);
            end
            held = result_o;
            hold = 3 + int'($urandom % 4);
            repeat (hold) begin
                @(negedge clk);
                check_eq("result_valid_o", 1'b1, result_valid_o);
                check_eq("issue_ready_o", 1'b0, issue_ready_o);
                compare_result(held, result_o);
            end
            @(posedge clk);
            result_ready_i <= 1'b1;
            @(negedge clk);
            compare_result(exp_q.pop_front(), result_o);
            @(posedge clk);
            result_ready_i <= 1'b0;
        end
    endtask

    task automatic backpressure_order();
        ex_pkg::ex_issue_t  seq [$];
        ex_pkg::ex_result_t exp_q [$];
        int                 pick;
        for (int i = 0; i < 30; i++) begin
            pick = int'($urandom % 3);
            case (pick)
                0: seq.push_back(make_instr(rv_isa_pkg::ex_op_e'(6'($urandom % 17)),
                                            rand64(), rand64()));
                1: seq.push_back(make_instr(rv_isa_pkg::ex_op_e'(6'(32 + $urandom % 5)),
                                            rand64(), rand64()));
                default: seq.push_back(make_instr(rv_isa_pkg::ex_op_e'(6'(48 + $urandom % 8)),
                                                  rand64(), rand64() >> ($urandom % 64)));
            endcase
        end
        foreach (seq[i]) begin
            exp_q.push_back(expected_result(seq[i]));
        end
        @(posedge clk);
        result_ready_i <= 1'b0;
        fork
            begin
                foreach (seq[i]) begin
                    send_instr(seq[i]);
                end
            end
            collect_results(exp_q);
        join
        // nothing extra may come out
        repeat (20) begin
            @(negedge clk);
            check_eq("result_valid_o", 1'b0, result_valid_o);
        end
    endtask

    initial begin
        void'($urandom(32'hbad490ec));
        rst_n_i        = 1'b0;
        issue_valid_i  = 1'b0;
        issue_i        = '0;
        result_ready_i = 1'b0;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        check_reset_state();
        @(posedge clk);
        result_ready_i <= 1'b1;
        alu_ops();
        multiply_ops();
        divide_ops();
        backpressure_order();
        $display("Everything OK");
        $finish;
    end

endmodule
